// File: Bender.yml
package:
  name: arrayHeap

sources:
  - files:
      - common/heapConfigPkg.sv
      - common/heapOpsPkg.sv
      - arrayAllocator/arrayAllocator.sv
      - heapController/heapController.sv
      - source/elementStore.sv
      - source/elementAlu.sv
      - source/arrayHeap.sv
  - target: test
    files:
      - tests/heapChecker.sv
      - tests/arrayHeapTb.sv

// File: arrayAllocator/arrayAllocator.sv
//--------------------
// Array allocator
// Hands out array ids, reusing freed ones last in first out
//--------------------
`timescale 1ns/1ps
`default_nettype none

module arrayAllocator
  import heapConfigPkg::*;
(
  input  wire         clock,
  input  wire         reset,
  input  wire         allocRequest,
  input  wire         freeRequest,
  input  wire         clearRequest,                    // Reset action
  input  wire arrayId freeId,
  input  wire arrayId queryId,
  output logic        isAllocated,
  output logic        inRange,
  output arrayId      grantedId,
  output logic        noSpace
);

  logic [addressBits:0]  freshCount;                   // Next never-used id
  logic [addressBits:0]  stackTop;                     // Entries on freed stack
  logic [addressBits:0]  stackBelow;
  logic [arrayCount-1:0] allocated;                    // One flag per array
  logic                  stackEmpty;
  arrayId                freedIds [arrayCount];

  // Flags --------------------
  assign stackEmpty  = (stackTop == '0);
  assign stackBelow  = stackTop - 1'b1;
  assign grantedId   = stackEmpty ? freshCount[addressBits-1:0] :
                                    freedIds[stackBelow[addressBits-1:0]];
  assign noSpace     = stackEmpty && (freshCount == (addressBits + 1)'(arrayCount));
  assign inRange     = {1'b0, queryId} < freshCount;
  assign isAllocated = allocated[queryId];

  // Counters and flags --------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      freshCount <= '0;
      stackTop   <= '0;
      allocated  <= '0;
    end else if (clearRequest) begin
      freshCount <= '0;
      stackTop   <= '0;
      allocated  <= '0;
    end else if (allocRequest && !noSpace) begin
      if (stackEmpty) begin
        freshCount <= freshCount + 1'b1;
      end else begin
        stackTop <= stackBelow;                        // Reuse latest freed
      end
      allocated[grantedId] <= 1'b1;
    end else if (freeRequest) begin
      stackTop          <= stackTop + 1'b1;
      allocated[freeId] <= 1'b0;
    end
  end

  // Freed ids, at most one per allocated array
  always_ff @(posedge clock) begin
    if (freeRequest && !clearRequest) begin
      freedIds[stackTop[addressBits-1:0]] <= freeId;
    end
  end

endmodule

`default_nettype wire

// File: arrayHeap.f
common/heapConfigPkg.sv
common/heapOpsPkg.sv
arrayAllocator/arrayAllocator.sv
heapController/heapController.sv
source/elementStore.sv
source/elementAlu.sv
source/arrayHeap.sv
tests/heapChecker.sv
tests/arrayHeapTb.sv

// File: common/heapConfigPkg.sv
//--------------------
// Heap configuration
// Widths and counts of the array heap, with the vector types
// built from them
//--------------------
`default_nettype none

package heapConfigPkg;

  // Sizes --------------------
  localparam int addressBits = 3;                     // Bits in an array number
  localparam int indexBits   = 3;                     // Bits in an element index
  localparam int dataBits    = 16;                    // Bits in one element
  localparam int arrayCount  = 8;                     // Arrays in the heap
  localparam int arrayLength = 8;                     // Elements per array

  // Vector types --------------------
  typedef logic [addressBits-1:0] arrayId;            // Names one array
  typedef logic [indexBits-1:0]   elementIndex;       // Position within an array
  typedef logic [dataBits-1:0]    elementData;        // One stored element

  // One extra bit so that a full array can report arrayLength
  typedef logic [indexBits:0]     arraySize;          // Size 0 to arrayLength

endpackage

`default_nettype wire

// File: common/heapOpsPkg.sv
//--------------------
// Heap operations
// Command actions and error kinds seen on the bus
//--------------------
`default_nettype none

package heapOpsPkg;

  // Actions --------------------
  // Encodings leave gaps between the groups
  typedef enum logic [7:0] {
    actReset      = 8'd1,                             // Empty the allocator
    actWrite      = 8'd2,                             // Write one element
    actRead       = 8'd3,                             // Read one element
    actSize       = 8'd4,                             // Current array size
    actPush       = 8'd14,                            // Append at the top
    actPop        = 8'd15,                            // Remove from the top
    actAlloc      = 8'd18,                            // Take an array
    actFree       = 8'd19,                            // Give an array back
    actAdd        = 8'd20,                            // Add then answer new value
    actAddAfter   = 8'd21,                            // Add but answer old value
    actSubtract   = 8'd22,                            // Subtract then answer new value
    actSubAfter   = 8'd23,                            // Subtract but answer old value
    actShiftLeft  = 8'd24,                            // Shift left by dataIn
    actShiftRight = 8'd25,                            // Shift right by dataIn
    actNotLogical = 8'd26,                            // 1 when zero and 0 otherwise
    actNot        = 8'd27,                            // Bitwise invert
    actOr         = 8'd28,
    actXor        = 8'd29,
    actAnd        = 8'd30
  } heapAction;

  // Error kinds --------------------
  typedef enum logic [2:0] {
    errNone         = 3'd0,
    errNotAllocated = 3'd1,                           // Beyond the fresh counter
    errFreed        = 3'd2,                           // Array was given back
    errOutOfBounds  = 3'd3,                           // Index at or past size
    errFull         = 3'd4,                           // Push on a full array
    errEmpty        = 3'd5,                           // Pop on an empty array
    errOutOfMemory  = 3'd6                            // No array left to grant
  } heapError;

  // True for the read-modify-write element actions
  function automatic logic isElementOp(input heapAction action);
    return action inside {[actAdd:actAnd]};
  endfunction

endpackage

`default_nettype wire

// File: heapController/heapController.sv
//--------------------
// Heap controller
// Wishbone handshake, command FSM and the access checks
//--------------------
`timescale 1ns/1ps
`default_nettype none

module heapController
  import heapConfigPkg::*;
  import heapOpsPkg::*;
(
  input  wire                       clock,
  input  wire                       reset,
  input  wire                       cycle,
  input  wire                       strobe,
  input  wire heapAction            action,
  input  wire arrayId               arrayNumber,
  input  wire heapConfigPkg::elementIndex elementIndex,
  input  wire elementData           dataIn,
  input  wire                       isAllocated,
  input  wire                       inRange,
  input  wire arrayId               grantedId,
  input  wire                       noSpace,
  input  wire elementData           storedElement,
  input  wire arraySize             currentSize,
  input  wire elementData           aluResult,
  input  wire elementData           aluAnswer,
  output logic                      acknowledge,
  output elementData                dataOut,       // Valid with errNone only
  output heapError                  errorKind,
  output logic                      allocRequest,
  output logic                      freeRequest,
  output logic                      clearRequest,
  output arrayId                    storeAddress,
  output heapConfigPkg::elementIndex storeIndex,
  output logic                      storeWrite,
  output elementData                storeData,
  output logic                      sizeWrite,
  output arraySize                  newSize
);

  typedef enum logic [1:0] {Idle, Fetch, Execute, Respond} controlState;

  controlState state;
  controlState stateNext;
  logic        request;
  logic        commit;
  heapError    writeError;
  heapError    readError;
  heapError    checkError;
  elementData  answer;
  arraySize    indexPlusOne;
  arraySize    sizeBelow;
  logic        wantStore;
  logic        wantSize;
  logic        wantAlloc;
  logic        wantFree;
  logic        wantClear;

  // Handshake --------------------
  assign request     = cycle && strobe;
  assign acknowledge = (state == Respond);             // One cycle wide

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      state <= Idle;
    end else begin
      state <= stateNext;
    end
  end

  always_comb begin
    case (state)
      Idle:    stateNext = request ? Fetch : Idle;
      Fetch:   stateNext = request ? Execute : Idle;  // Dropped strobe abandons
      Execute: stateNext = request ? Respond : Idle;
      default: stateNext = Idle;
    endcase
  end

  // Store addressing --------------------
  assign indexPlusOne = arraySize'(elementIndex) + arraySize'(1);
  assign sizeBelow    = currentSize - arraySize'(1);
  assign storeAddress = (action == actAlloc) ? grantedId : arrayNumber;
  assign storeData    = aluResult;                     // dataIn unless arithmetic

  always_comb begin
    storeIndex = elementIndex;
    if (action == actPop && state == Fetch) begin
      storeIndex = sizeBelow[indexBits-1:0];           // Top element for Pop
    end else if (action == actPush && state == Execute) begin
      storeIndex = currentSize[indexBits-1:0];         // First free slot
    end
  end

  // Access checks --------------------
  assign writeError = !inRange     ? errNotAllocated :
                      !isAllocated ? errFreed : errNone;
  assign readError  = (writeError != errNone) ? writeError :
                      (arraySize'(elementIndex) < currentSize) ? errNone : errOutOfBounds;

  always_comb begin
    checkError = errNone;
    answer     = '0;
    wantStore  = 1'b0;
    wantSize   = 1'b0;
    wantAlloc  = 1'b0;
    wantFree   = 1'b0;
    wantClear  = 1'b0;
    newSize    = currentSize;
    case (action)
      actReset: wantClear = 1'b1;
      actWrite: begin
        checkError = writeError;
        wantStore  = 1'b1;
        answer     = dataIn;
        if (indexPlusOne > currentSize) begin          // Grow to cover index
          wantSize = 1'b1;
          newSize  = indexPlusOne;
        end
      end
      actRead: begin
        checkError = readError;
        answer     = storedElement;
      end
      actSize: begin
        checkError = writeError;
        answer     = elementData'(currentSize);
      end
      actPush: begin
        checkError = writeError;
        if (writeError == errNone && currentSize == arraySize'(arrayLength)) begin
          checkError = errFull;
        end
        wantStore = 1'b1;
        wantSize  = 1'b1;
        newSize   = currentSize + arraySize'(1);
        answer    = dataIn;
      end
      actPop: begin
        checkError = writeError;
        if (writeError == errNone && currentSize == '0) begin
          checkError = errEmpty;
        end
        wantSize = 1'b1;
        newSize  = sizeBelow;
        answer   = storedElement;
      end
      actAlloc: begin
        checkError = noSpace ? errOutOfMemory : errNone;
        wantAlloc  = 1'b1;
        wantSize   = 1'b1;                             // Fresh array starts empty
        newSize    = '0;
        answer     = elementData'(grantedId);
      end
      actFree: begin
        checkError = writeError;
        wantFree   = 1'b1;
        answer     = elementData'(arrayNumber);
      end
      default: begin
        if (isElementOp(action)) begin
          checkError = readError;
          wantStore  = 1'b1;
          answer     = aluAnswer;
        end
      end
    endcase
  end

  // Commit only once per accepted command
  assign commit       = (state == Execute) && request && (checkError == errNone);
  assign storeWrite   = commit && wantStore;
  assign sizeWrite    = commit && wantSize;
  assign allocRequest = commit && wantAlloc;
  assign freeRequest  = commit && wantFree;
  assign clearRequest = commit && wantClear;

  // Response registers --------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      errorKind <= errNone;
    end else if (state == Execute) begin
      errorKind <= checkError;
    end
  end

  always_ff @(posedge clock) begin
    if (state == Execute) begin
      dataOut <= answer;
    end
  end

endmodule

`default_nettype wire

// File: source/arrayHeap.sv
//--------------------
// Array heap top level
// Wishbone classic slave serving commands on a small heap of arrays
//--------------------
`timescale 1ns/1ps
`default_nettype none

module arrayHeap
  import heapConfigPkg::*;
  import heapOpsPkg::*;
(
  input  wire                       clock,
  input  wire                       reset,         // Active low
  input  wire                       cycle,
  input  wire                       strobe,
  input  wire                       writeEnable,   // Ignored since any action may write
  input  wire heapAction            action,
  input  wire arrayId               arrayNumber,
  input  wire heapConfigPkg::elementIndex elementIndex,
  input  wire elementData           dataIn,
  output logic                      acknowledge,
  output elementData                dataOut,
  output heapError                  errorKind
);

  // Allocator links --------------------
  logic       allocRequest;
  logic       freeRequest;
  logic       clearRequest;
  logic       isAllocated;
  logic       inRange;
  arrayId     grantedId;
  logic       noSpace;

  // Store and ALU links --------------------
  arrayId     storeAddress;
  heapConfigPkg::elementIndex storeIndex;
  logic       storeWrite;
  elementData storeData;
  logic       sizeWrite;
  arraySize   newSize;
  elementData storedElement;
  arraySize   currentSize;
  elementData aluResult;
  elementData aluAnswer;

  heapController controller (
    .clock(clock), .reset(reset),
    .cycle(cycle), .strobe(strobe), .action(action),
    .arrayNumber(arrayNumber), .elementIndex(elementIndex), .dataIn(dataIn),
    .isAllocated(isAllocated), .inRange(inRange),
    .grantedId(grantedId), .noSpace(noSpace),
    .storedElement(storedElement), .currentSize(currentSize),
    .aluResult(aluResult), .aluAnswer(aluAnswer),
    .acknowledge(acknowledge), .dataOut(dataOut), .errorKind(errorKind),
    .allocRequest(allocRequest), .freeRequest(freeRequest),
    .clearRequest(clearRequest),
    .storeAddress(storeAddress), .storeIndex(storeIndex),
    .storeWrite(storeWrite), .storeData(storeData),
    .sizeWrite(sizeWrite), .newSize(newSize)
  );

  arrayAllocator allocator (
    .clock(clock), .reset(reset),
    .allocRequest(allocRequest), .freeRequest(freeRequest),
    .clearRequest(clearRequest),
    .freeId(arrayNumber),                          // Free names the bus array
    .queryId(arrayNumber),
    .isAllocated(isAllocated), .inRange(inRange),
    .grantedId(grantedId), .noSpace(noSpace)
  );

  elementStore store (
    .clock(clock), .reset(reset),
    .storeAddress(storeAddress), .storeIndex(storeIndex),
    .storeWrite(storeWrite), .storeData(storeData),
    .sizeWrite(sizeWrite), .newSize(newSize),
    .storedElement(storedElement), .currentSize(currentSize)
  );

  elementAlu alu (
    .action(action), .storedElement(storedElement), .dataIn(dataIn),
    .aluResult(aluResult), .aluAnswer(aluAnswer)
  );

endmodule

`default_nettype wire

// File: source/elementAlu.sv
//--------------------
// Element ALU
// New element value and answer for arithmetic actions
//--------------------
`timescale 1ns/1ps
`default_nettype none

module elementAlu
  import heapConfigPkg::*;
  import heapOpsPkg::*;
(
  input  wire heapAction  action,
  input  wire elementData storedElement,
  input  wire elementData dataIn,
  output elementData      aluResult,                   // Value to write back
  output elementData      aluAnswer                    // Value for the bus
);

  always_comb begin
    case (action)
      actAdd,
      actAddAfter:   aluResult = storedElement + dataIn;
      actSubtract,
      actSubAfter:   aluResult = storedElement - dataIn;
      actShiftLeft:  aluResult = storedElement << dataIn;   // Amount from dataIn
      actShiftRight: aluResult = storedElement >> dataIn;
      actNotLogical: aluResult = elementData'(storedElement == '0);
      actNot:        aluResult = ~storedElement;
      actOr:         aluResult = storedElement | dataIn;
      actXor:        aluResult = storedElement ^ dataIn;
      actAnd:        aluResult = storedElement & dataIn;
      default:       aluResult = dataIn;              // Plain writes and pushes
    endcase
  end

  // After forms report the element before the update
  assign aluAnswer = (action == actAddAfter || action == actSubAfter) ?
                     storedElement : aluResult;

endmodule

`default_nettype wire

// File: source/elementStore.sv
//--------------------
// Element store
// Element memory of every array plus its size table
//--------------------
`timescale 1ns/1ps
`default_nettype none

module elementStore
  import heapConfigPkg::*;
(
  input  wire              clock,
  input  wire              reset,
  input  wire arrayId      storeAddress,
  input  wire elementIndex storeIndex,
  input  wire              storeWrite,
  input  wire elementData  storeData,
  input  wire              sizeWrite,
  input  wire arraySize    newSize,
  output elementData       storedElement,              // One cycle after address
  output arraySize         currentSize                 // Same timing
);

  elementData memory [arrayCount][arrayLength];        // Fixed block per array
  arraySize   sizes  [arrayCount];

  // Element memory --------------------
  // Read returns the old value on a same-edge write
  always_ff @(posedge clock) begin
    if (storeWrite) begin
      memory[storeAddress][storeIndex] <= storeData;
    end
    storedElement <= memory[storeAddress][storeIndex];
  end

  // Size table --------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      for (int i = 0; i < arrayCount; i++) begin
        sizes[i] <= '0;                                // All arrays empty
      end
      currentSize <= '0;
    end else begin
      if (sizeWrite) begin
        sizes[storeAddress] <= newSize;
      end
      currentSize <= sizes[storeAddress];
    end
  end

endmodule

`default_nettype wire

// File: tests/arrayHeapTb.sv
//--------------------
// Array heap testbench
// Clock, reset and a Wishbone master walking the heap commands
//--------------------
`timescale 1ns/1ps
`default_nettype none

module arrayHeapTb
  import heapConfigPkg::*;
  import heapOpsPkg::*;
();

  localparam int ackLatency = 3;                       // Edges from request to acknowledge
  localparam int ackTimeout = 20;                      // Cycles before giving up

  logic                       clock;
  logic                       reset;
  logic                       cycle;
  logic                       strobe;
  logic                       writeEnable;
  heapAction                  action;
  arrayId                     arrayNumber;
  heapConfigPkg::elementIndex elementPos;
  elementData                 dataIn;
  logic                       acknowledge;
  elementData                 dataOut;
  heapError                   errorKind;
  logic [31:0]                rngState;
  int                         commandCount;
  int                         protocolErrors;
  int                         mismatchCount;
  int                         responseCount;
  int                         fillCount [3];           // Written prefix per array

  arrayHeap dut (
    .clock(clock), .reset(reset), .cycle(cycle), .strobe(strobe),
    .writeEnable(writeEnable), .action(action), .arrayNumber(arrayNumber),
    .elementIndex(elementPos), .dataIn(dataIn),
    .acknowledge(acknowledge), .dataOut(dataOut), .errorKind(errorKind)
  );

  heapChecker responseChecker (
    .clock(clock), .acknowledge(acknowledge), .action(action),
    .arrayNumber(arrayNumber), .elementPos(elementPos), .dataIn(dataIn),
    .dataOut(dataOut), .errorKind(errorKind),
    .mismatchCount(mismatchCount), .responseCount(responseCount)
  );

  initial begin
    clock = 1'b0;
    forever begin
      #20 clock = ~clock;                              // 40 ns period
    end
  end

  // Random source --------------------
  function automatic logic [31:0] xorshift(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] nextRandom();
    rngState = xorshift(rngState);
    return rngState;
  endfunction

  // One bus command, held until acknowledge
  task automatic sendCommand(input heapAction act, input int arr, input int idx,
                             input elementData value);
    int waited;
    @(posedge clock);
    #2;
    cycle       = 1'b1;
    strobe      = 1'b1;
    action      = act;
    arrayNumber = arr[addressBits-1:0];
    elementPos  = idx[indexBits-1:0];
    dataIn      = value;
    commandCount++;
    waited = 0;
    while (!acknowledge && waited < ackTimeout) begin
      @(posedge clock);
      #1;                                              // Past the state update
      waited++;
    end
    if (!acknowledge) begin
      $display("Timed out after %0d cycles waiting for acknowledge of %s", waited, act.name());
      $display(">>> FAIL");
      $finish;
    end else begin
      if (waited != ackLatency) begin
        $display("ERROR at %0t: %s acknowledged after %0d cycles, expected %0d",
                 $time, act.name(), waited, ackLatency);
        protocolErrors++;
      end
      #1;
      cycle  = 1'b0;                                   // Release the bus
      strobe = 1'b0;
    end
  endtask

  initial begin
    int arr;
    int idx;
    elementData value;
    cycle          = 1'b0;
    strobe         = 1'b0;
    writeEnable    = 1'b0;
    action         = actReset;
    arrayNumber    = '0;
    elementPos     = '0;
    dataIn         = '0;
    reset          = 1'b0;
    rngState       = 32'h61cb79f5;
    commandCount   = 0;
    protocolErrors = 0;
    repeat (3) @(posedge clock);
    #2 reset = 1'b1;

    // Allocation order --------------------
    sendCommand(actReset, 0, 0, '0);
    repeat (3) sendCommand(actAlloc, 0, 0, '0);        // Grants 0, 1, 2
    sendCommand(actFree, 1, 0, '0);
    sendCommand(actFree, 0, 0, '0);
    repeat (2) sendCommand(actAlloc, 0, 0, '0);        // Last freed comes back first

    // Writes, reads and sizes --------------------
    for (int a = 0; a < 3; a++) begin
      fillCount[a] = 2 + nextRandom() % 5;
      for (int i = 0; i < fillCount[a]; i++) begin
        sendCommand(actWrite, a, i, elementData'(nextRandom()));
      end
    end
    repeat (12) begin
      arr = nextRandom() % 3;
      idx = nextRandom() % (fillCount[arr] + 1);       // May extend by one
      if (idx >= arrayLength) begin
        idx = arrayLength - 1;
      end
      if (idx == fillCount[arr]) begin
        fillCount[arr]++;
      end
      sendCommand(actWrite, arr, idx, elementData'(nextRandom()));
    end
    for (int a = 0; a < 3; a++) begin
      for (int i = 0; i < arrayLength; i++) begin
        sendCommand(actRead, a, i, '0);                // Past the size is out of bounds
      end
      sendCommand(actSize, a, 0, '0);
    end
    sendCommand(actAlloc, 0, 0, '0);                   // Fresh array 3
    sendCommand(actRead, 3, 0, '0);

    // Stack --------------------
    for (int i = 0; i <= arrayLength; i++) begin
      sendCommand(actPush, 3, 0, elementData'(nextRandom()));  // Last one is full
    end
    for (int i = 0; i <= arrayLength; i++) begin
      sendCommand(actPop, 3, 0, '0);                   // Last one is empty
    end

    // Element arithmetic --------------------
    for (int a = 0; a < 3; a++) begin
      for (int i = 0; i < arrayLength; i++) begin
        sendCommand(actWrite, a, i, elementData'(nextRandom()));
      end
    end
    repeat (2) begin
      for (int op = actAdd; op <= actAnd; op++) begin
        arr   = nextRandom() % 3;
        idx   = nextRandom() % arrayLength;
        value = elementData'(nextRandom());
        if (op == actShiftLeft || op == actShiftRight) begin
          value = value % 20;                          // Some shifts past the width
        end
        sendCommand(heapAction'(op), arr, idx, value);
        sendCommand(actRead, arr, idx, '0);
      end
    end

    // Access errors --------------------
    sendCommand(actFree, 2, 0, '0);
    sendCommand(actRead, 2, 0, '0);
    sendCommand(actWrite, 2, 1, 16'h1234);
    sendCommand(actPush, 2, 0, 16'h5678);
    sendCommand(actAdd, 2, 0, 16'h0001);
    sendCommand(actFree, 2, 0, '0);
    sendCommand(actRead, 6, 0, '0);                    // Never handed out
    sendCommand(actSize, 7, 0, '0);
    sendCommand(actFree, 5, 0, '0);
    repeat (5) sendCommand(actAlloc, 0, 0, '0);        // Takes the last arrays
    sendCommand(actAlloc, 0, 0, '0);                   // Ninth one

    repeat (2) @(posedge clock);                       // Checker sees the last response
    $display("Commands %0d, responses %0d, mismatches %0d, protocol errors %0d",
             commandCount, responseCount, mismatchCount, protocolErrors);
    if (mismatchCount == 0 && protocolErrors == 0 && responseCount == commandCount) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/heapChecker.sv
//--------------------
// Heap response checker
// Models the heap and compares every acknowledged response
//--------------------
`timescale 1ns/1ps
`default_nettype none

module heapChecker
  import heapConfigPkg::*;
  import heapOpsPkg::*;
(
  input  wire                             clock,
  input  wire                             acknowledge,
  input  wire heapAction                  action,
  input  wire arrayId                     arrayNumber,
  input  wire heapConfigPkg::elementIndex elementPos,
  input  wire elementData                 dataIn,
  input  wire elementData                 dataOut,
  input  wire heapError                   errorKind,
  output int                              mismatchCount,
  output int                              responseCount
);

  int                    freshCount;                   // Next never-used array
  int                    freeStack [$];                // Freed arrays, top at the back
  logic [arrayCount-1:0] allocated;
  int                    sizes [arrayCount];
  elementData            elements [arrayCount][arrayLength];
  logic                  ackBefore;

  initial begin
    freshCount    = 0;
    allocated     = '0;
    mismatchCount = 0;
    responseCount = 0;
    ackBefore     = 1'b0;
    for (int i = 0; i < arrayCount; i++) begin
      sizes[i] = 0;                                    // Heap starts empty
    end
  end

  // Element arithmetic --------------------
  function automatic elementData arithValue(input heapAction act, input elementData old,
                                            input elementData operand);
    case (act)
      actAdd, actAddAfter:      return old + operand;
      actSubtract, actSubAfter: return old - operand;
      actShiftLeft:             return (operand >= dataBits) ? elementData'(0) : old << operand;
      actShiftRight:            return (operand >= dataBits) ? elementData'(0) : old >> operand;
      actNotLogical:            return (old == 0) ? elementData'(1) : elementData'(0);
      actNot:                   return ~old;
      actOr:                    return old | operand;
      actXor:                   return old ^ operand;
      default:                  return old & operand;
    endcase
  endfunction

  // Reference model --------------------
  function automatic void predict(input heapAction act, input int arr, input int idx,
                                  input elementData operand, output elementData expData,
                                  output heapError expError, output logic dataValid);
    int         id;
    elementData newValue;
    expError  = (arr >= freshCount) ? errNotAllocated :
                !allocated[arr] ? errFreed : errNone;
    expData   = '0;
    dataValid = 1'b0;
    case (act)
      actReset: begin
        expError   = errNone;                          // No access check
        freshCount = 0;
        freeStack.delete();
        allocated  = '0;
      end
      actAlloc: begin
        if (freeStack.size() == 0 && freshCount == arrayCount) begin
          expError = errOutOfMemory;
        end else begin
          expError = errNone;
          if (freeStack.size() != 0) begin
            id = freeStack.pop_back();                 // Last freed first
          end else begin
            id = freshCount;
            freshCount++;
          end
          allocated[id] = 1'b1;
          sizes[id]     = 0;
          expData       = elementData'(id);
          dataValid     = 1'b1;
        end
      end
      actFree: begin
        if (expError == errNone) begin
          freeStack.push_back(arr);
          allocated[arr] = 1'b0;
        end
      end
      actWrite: begin
        if (expError == errNone) begin
          elements[arr][idx] = operand;
          if (idx + 1 > sizes[arr]) begin
            sizes[arr] = idx + 1;                      // Grows to cover index
          end
        end
      end
      actRead: begin
        if (expError == errNone && idx >= sizes[arr]) begin
          expError = errOutOfBounds;
        end
        expData   = elements[arr][idx];
        dataValid = 1'b1;
      end
      actSize: begin
        expData   = elementData'(sizes[arr]);
        dataValid = 1'b1;
      end
      actPush: begin
        if (expError == errNone && sizes[arr] == arrayLength) begin
          expError = errFull;
        end else if (expError == errNone) begin
          elements[arr][sizes[arr]] = operand;
          sizes[arr]++;
        end
      end
      actPop: begin
        if (expError == errNone && sizes[arr] == 0) begin
          expError = errEmpty;
        end else if (expError == errNone) begin
          sizes[arr]--;
          expData   = elements[arr][sizes[arr]];       // Top element
          dataValid = 1'b1;
        end
      end
      default: begin
        if (expError == errNone && idx >= sizes[arr]) begin
          expError = errOutOfBounds;
        end
        if (expError == errNone) begin
          newValue  = arithValue(act, elements[arr][idx], operand);
          expData   = (act == actAddAfter || act == actSubAfter) ?
                      elements[arr][idx] : newValue;   // After forms give the old value
          elements[arr][idx] = newValue;
          dataValid = 1'b1;
        end
      end
    endcase
    dataValid = dataValid && (expError == errNone);
  endfunction

  // Comparison at the middle of the acknowledge cycle
  always @(negedge clock) begin
    elementData expData;
    heapError   expError;
    logic       dataValid;
    if (acknowledge && ackBefore) begin
      $display("ERROR at %0t: acknowledge high for more than one cycle", $time);
      mismatchCount++;
    end else if (acknowledge) begin
      predict(action, arrayNumber, elementPos, dataIn, expData, expError, dataValid);
      responseCount++;
      if (errorKind !== expError) begin
        $display("ERROR at %0t: action %0d array %0d index %0d gave error %0d, expected %0d",
                 $time, action, arrayNumber, elementPos, errorKind, expError);
        mismatchCount++;
      end else if (dataValid && dataOut !== expData) begin
        $display("ERROR at %0t: action %0d array %0d index %0d gave data %h, expected %h",
                 $time, action, arrayNumber, elementPos, dataOut, expData);
        mismatchCount++;
      end
    end
    ackBefore = acknowledge;
  end

endmodule

`default_nettype wire
